// ==== l2_params.svh ====
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// address split of the l1 request

// tag bits above the set index
`define L2_TAG_W    21

// set index bits
`define L2_INDEX_W  5

// way number bits
`define L2_WAY_W    2

// cache geometry

`define L2_WAYS     4

`define L2_SETS     32

`endif

// ==== l2_addr_pkg.sv ====
package l2_addr_pkg;

`include "l2_params.svh"

    // request tag
    typedef logic [`L2_TAG_W-1:0] tag_t;

    // set index
    typedef logic [`L2_INDEX_W-1:0] index_t;

    typedef logic [`L2_WAY_W-1:0] way_t;

    // line number is {index, way}
    typedef logic [`L2_INDEX_W+`L2_WAY_W-1:0] line_t;

endpackage

// ==== l2_ctrl_pkg.sv ====
package l2_ctrl_pkg;

`include "l2_params.svh"

    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPARE,
        S_WRITE_BACK,
        S_ALLOCATE
    } l2_state_t;

    // 0 is most recent, all ones is least recent
    typedef logic [`L2_WAY_W-1:0] lru_age_t;

endpackage

// ==== l2_tag_store.sv ====
`timescale 1ns/1ps

`include "l2_params.svh"

module l2_tag_store (
    input  logic                clk,
    input  logic                nrst,
    input  l2_addr_pkg::tag_t   tag_l1_l2,
    input  l2_addr_pkg::index_t index_l1_l2,
    input  l2_addr_pkg::way_t   lru_way,
    input  l2_addr_pkg::way_t   sel_way,
    input  logic                alloc,
    input  logic                mark_dirty,
    input  logic                invalidate,
    output logic                hit,
    output l2_addr_pkg::way_t   hit_way,
    output l2_addr_pkg::way_t   victim_way,
    output logic                victim_dirty,
    output l2_addr_pkg::tag_t   sel_tag
);

    localparam int LINES = `L2_SETS * `L2_WAYS;

    l2_addr_pkg::tag_t  tag_arr [LINES];
    logic [LINES-1:0]   valid;
    logic [LINES-1:0]   dirty;

    l2_addr_pkg::line_t sel_line;
    logic [`L2_WAYS-1:0] way_valid;
    logic [`L2_WAYS-1:0] way_dirty;
    logic [`L2_WAYS-1:0] way_match;
    logic               any_free;
    l2_addr_pkg::way_t  free_way;

    assign sel_line = {index_l1_l2, sel_way};
    // tag of the working way, also the write-back address
    assign sel_tag = tag_arr[sel_line];

    // per-way view of the indexed set
    for (genvar w = 0; w < `L2_WAYS; w++)
    begin : g_way
        l2_addr_pkg::line_t line;

        assign line = {index_l1_l2, l2_addr_pkg::way_t'(w)};
        assign way_valid[w] = valid[line];
        assign way_dirty[w] = dirty[line];
        assign way_match[w] = valid[line] && (tag_arr[line] == tag_l1_l2);
    end

    // downward scan so the lowest way wins
    always_comb
    begin
        hit_way = '0;
        free_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (way_match[w])
                hit_way = l2_addr_pkg::way_t'(w);
            if (!way_valid[w])
                free_way = l2_addr_pkg::way_t'(w);
        end
    end

    assign hit = |way_match;
    assign any_free = ~&way_valid;

    // fill empty ways before evicting the oldest one
    assign victim_way = any_free ? free_way : lru_way;
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

    always_ff @(posedge clk)
    begin
        if (alloc)
            tag_arr[sel_line] <= tag_l1_l2;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (invalidate)
        begin
            // flush drops dirty data too
            valid <= '0;
            dirty <= '0;
        end
        else if (alloc)
        begin
            valid[sel_line] <= 1'b1;
            dirty[sel_line] <= 1'b0;
        end
        else if (mark_dirty)
        begin
            dirty[sel_line] <= 1'b1;
        end
    end

endmodule

// ==== l2_lru_tracker.sv ====
`timescale 1ns/1ps

`include "l2_params.svh"

module l2_lru_tracker (
    input  logic                clk,
    input  logic                nrst,
    input  l2_addr_pkg::index_t index_l1_l2,
    input  logic                touch,
    input  l2_addr_pkg::way_t   touch_way,
    output l2_addr_pkg::way_t   lru_way
);

    localparam l2_ctrl_pkg::lru_age_t AGE_OLDEST = '1;

    l2_ctrl_pkg::lru_age_t age [`L2_SETS][`L2_WAYS];
    l2_ctrl_pkg::lru_age_t touched_age;

    assign touched_age = age[index_l1_l2][touch_way];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            // way n starts with age n
            for (int s = 0; s < `L2_SETS; s++)
            begin
                for (int w = 0; w < `L2_WAYS; w++)
                begin
                    age[s][w] <= l2_ctrl_pkg::lru_age_t'(w);
                end
            end
        end
        else if (touch)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                if (l2_addr_pkg::way_t'(w) == touch_way)
                    age[index_l1_l2][w] <= '0;
                else if (age[index_l1_l2][w] < touched_age)
                    age[index_l1_l2][w] <= age[index_l1_l2][w] + 1'b1;
            end
        end
    end

    // ages stay a permutation so exactly one way is oldest
    always_comb
    begin
        lru_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (age[index_l1_l2][w] == AGE_OLDEST)
                lru_way = l2_addr_pkg::way_t'(w);
        end
    end

endmodule

// ==== l2_sequencer.sv ====
`timescale 1ns/1ps

module l2_sequencer (
    input  logic              clk,
    input  logic              nrst,
    input  logic              read_l1_l2,
    input  logic              write_l1_l2,
    input  logic              flush,
    input  logic              ready_mem_l2,
    input  logic              hit,
    input  l2_addr_pkg::way_t hit_way,
    input  l2_addr_pkg::way_t victim_way,
    input  logic              victim_dirty,
    output logic              ready_l2_l1,
    output logic              update,
    output logic              refill,
    output logic              read_l2_mem,
    output logic              write_l2_mem,
    output logic              l2_miss,
    output l2_addr_pkg::way_t way,
    output l2_addr_pkg::way_t sel_way,
    output logic              alloc,
    output logic              mark_dirty,
    output logic              touch,
    output logic              invalidate
);

    l2_ctrl_pkg::l2_state_t state;
    l2_ctrl_pkg::l2_state_t next_state;

    logic req;
    logic hit_q;
    logic first_cmp;

    assign req = read_l1_l2 || write_l1_l2;

    // tags are looked at once per compare visit, hit_q marks the answer cycle
    assign first_cmp = (state == l2_ctrl_pkg::S_COMPARE) && !hit_q;

    assign touch = first_cmp && hit;
    assign mark_dirty = (state == l2_ctrl_pkg::S_COMPARE) && hit_q && write_l1_l2;
    assign alloc = (state == l2_ctrl_pkg::S_ALLOCATE) && ready_mem_l2;
    assign invalidate = (state == l2_ctrl_pkg::S_IDLE) && flush && !req;
    assign sel_way = way;

    always_comb
    begin
        next_state = state;
        case (state)
            l2_ctrl_pkg::S_IDLE:
            begin
                // request still held while ready is out
                if (req && !ready_l2_l1)
                    next_state = l2_ctrl_pkg::S_COMPARE;
            end
            l2_ctrl_pkg::S_COMPARE:
            begin
                if (hit_q)
                    next_state = l2_ctrl_pkg::S_IDLE;
                else if (!hit && victim_dirty)
                    next_state = l2_ctrl_pkg::S_WRITE_BACK;
                else if (!hit)
                    next_state = l2_ctrl_pkg::S_ALLOCATE;
            end
            l2_ctrl_pkg::S_WRITE_BACK:
            begin
                if (ready_mem_l2)
                    next_state = l2_ctrl_pkg::S_ALLOCATE;
            end
            l2_ctrl_pkg::S_ALLOCATE:
            begin
                if (ready_mem_l2)
                    next_state = l2_ctrl_pkg::S_COMPARE;
            end
            default:
            begin
                next_state = l2_ctrl_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= l2_ctrl_pkg::S_IDLE;
            hit_q <= 1'b0;
            way <= '0;
            ready_l2_l1 <= 1'b0;
            update <= 1'b0;
            refill <= 1'b0;
            l2_miss <= 1'b0;
            read_l2_mem <= 1'b0;
            write_l2_mem <= 1'b0;
        end
        else
        begin
            state <= next_state;
            hit_q <= touch;
            ready_l2_l1 <= (state == l2_ctrl_pkg::S_COMPARE) && hit_q;
            update <= mark_dirty;
            refill <= alloc;
            l2_miss <= first_cmp && !hit;
            if (touch)
                way <= hit_way;
            else if (first_cmp)
                way <= victim_way;
            // memory strobes follow the state they belong to
            write_l2_mem <= (next_state == l2_ctrl_pkg::S_WRITE_BACK);
            read_l2_mem <= (next_state == l2_ctrl_pkg::S_ALLOCATE);
        end
    end

endmodule

// ==== l2_controller.sv ====
`timescale 1ns/1ps

module l2_controller (
    input  logic                clk,
    input  logic                nrst,
    input  l2_addr_pkg::tag_t   tag_l1_l2,
    input  l2_addr_pkg::index_t index_l1_l2,
    input  logic                read_l1_l2,
    input  logic                write_l1_l2,
    input  logic                flush,
    input  logic                ready_mem_l2,
    output logic                ready_l2_l1,
    output logic                refill,
    output logic                update,
    output logic                read_l2_mem,
    output logic                write_l2_mem,
    output l2_addr_pkg::index_t index_l2_mem,
    output l2_addr_pkg::tag_t   tag_l2_mem,
    output l2_addr_pkg::tag_t   write_tag_l2_mem,
    output l2_addr_pkg::way_t   way,
    output logic                l2_miss
);

    logic              hit;
    logic              victim_dirty;
    logic              alloc;
    logic              mark_dirty;
    logic              touch;
    logic              invalidate;
    l2_addr_pkg::way_t hit_way;
    l2_addr_pkg::way_t victim_way;
    l2_addr_pkg::way_t lru_way;
    l2_addr_pkg::way_t sel_way;

    // refill address is the request itself
    assign index_l2_mem = index_l1_l2;
    assign tag_l2_mem = tag_l1_l2;

    l2_tag_store tag_store_i (
        .clk          (clk),
        .nrst         (nrst),
        .tag_l1_l2    (tag_l1_l2),
        .index_l1_l2  (index_l1_l2),
        .lru_way      (lru_way),
        .sel_way      (sel_way),
        .alloc        (alloc),
        .mark_dirty   (mark_dirty),
        .invalidate   (invalidate),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .sel_tag      (write_tag_l2_mem)
    );

    l2_lru_tracker lru_tracker_i (
        .clk         (clk),
        .nrst        (nrst),
        .index_l1_l2 (index_l1_l2),
        .touch       (touch),
        .touch_way   (hit_way),
        .lru_way     (lru_way)
    );

    l2_sequencer sequencer_i (
        .clk          (clk),
        .nrst         (nrst),
        .read_l1_l2   (read_l1_l2),
        .write_l1_l2  (write_l1_l2),
        .flush        (flush),
        .ready_mem_l2 (ready_mem_l2),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .ready_l2_l1  (ready_l2_l1),
        .update       (update),
        .refill       (refill),
        .read_l2_mem  (read_l2_mem),
        .write_l2_mem (write_l2_mem),
        .l2_miss      (l2_miss),
        .way          (way),
        .sel_way      (sel_way),
        .alloc        (alloc),
        .mark_dirty   (mark_dirty),
        .touch        (touch),
        .invalidate   (invalidate)
    );

endmodule

// ==== l2_controller_checker.sv ====
`timescale 1ns/1ps

module l2_controller_checker (
    input logic clk,
    input logic nrst,
    input logic ready_l2_l1,
    input logic refill,
    input logic update,
    input logic l2_miss,
    input logic read_l2_mem,
    input logic write_l2_mem,
    input logic ready_mem_l2
);

    // sticky, watched by the testbench
    logic violation = 1'b0;

    mem_exclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(read_l2_mem && write_l2_mem))
    else
    begin
        violation = 1'b1;
        $error("memory read and write requested together");
    end

    // a memory request holds until memory answers
    read_held: assert property (@(posedge clk) disable iff (!nrst)
        read_l2_mem && !ready_mem_l2 |=> read_l2_mem)
    else
    begin
        violation = 1'b1;
        $error("read_l2_mem dropped before ready_mem_l2");
    end

    write_held: assert property (@(posedge clk) disable iff (!nrst)
        write_l2_mem && !ready_mem_l2 |=> write_l2_mem)
    else
    begin
        violation = 1'b1;
        $error("write_l2_mem dropped before ready_mem_l2");
    end

    ready_pulse: assert property (@(posedge clk) disable iff (!nrst)
        ready_l2_l1 |=> !ready_l2_l1)
    else
    begin
        violation = 1'b1;
        $error("ready_l2_l1 longer than one cycle");
    end

    refill_pulse: assert property (@(posedge clk) disable iff (!nrst)
        refill |=> !refill)
    else
    begin
        violation = 1'b1;
        $error("refill longer than one cycle");
    end

    miss_pulse: assert property (@(posedge clk) disable iff (!nrst)
        l2_miss |=> !l2_miss)
    else
    begin
        violation = 1'b1;
        $error("l2_miss longer than one cycle");
    end

    update_with_ready: assert property (@(posedge clk) disable iff (!nrst)
        update |-> ready_l2_l1)
    else
    begin
        violation = 1'b1;
        $error("update without ready_l2_l1");
    end

endmodule

// ==== tb_l2_controller.sv ====
`timescale 1ns/1ps

`include "l2_params.svh"

module tb_l2_controller;

    localparam int RESET_CYCLES = 10;
    // longest access is two memory waits of four cycles plus compare passes
    localparam int ACCESS_BUDGET = 20;
    localparam int N_ACCESSES = 12;
    localparam int MAX_CYCLES = RESET_CYCLES + N_ACCESSES * ACCESS_BUDGET;

    logic                clk = 1'b0;
    logic                nrst = 1'b0;
    l2_addr_pkg::tag_t   tag_l1_l2 = '0;
    l2_addr_pkg::index_t index_l1_l2 = '0;
    logic                read_l1_l2 = 1'b0;
    logic                write_l1_l2 = 1'b0;
    logic                flush = 1'b0;
    logic                ready_mem_l2 = 1'b0;
    logic                ready_l2_l1;
    logic                refill;
    logic                update;
    logic                read_l2_mem;
    logic                write_l2_mem;
    logic                l2_miss;
    l2_addr_pkg::index_t index_l2_mem;
    l2_addr_pkg::tag_t   tag_l2_mem;
    l2_addr_pkg::tag_t   write_tag_l2_mem;
    l2_addr_pkg::way_t   way;

    // reference copy of the tag state and ages
    l2_addr_pkg::tag_t     ref_tag [`L2_SETS][`L2_WAYS];
    logic                  ref_valid [`L2_SETS][`L2_WAYS];
    logic                  ref_dirty [`L2_SETS][`L2_WAYS];
    l2_ctrl_pkg::lru_age_t ref_age [`L2_SETS][`L2_WAYS];

    logic [31:0] mem_rng = 32'd93;
    logic        mem_armed = 1'b0;
    int          mem_wait = 0;
    int          cycles = 0;

    l2_controller l2_controller_i (.*);

    bind l2_controller l2_controller_checker checker_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
            abort_run($sformatf("** Error %s: expected 0x%0h, actual 0x%0h", test, exp, act));
    endtask

    task automatic clear_model(input logic reset_ages);
        for (int s = 0; s < `L2_SETS; s++)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                if (reset_ages)
                    ref_age[s][w] = l2_ctrl_pkg::lru_age_t'(w);
            end
        end
    endtask

    // lowest invalid way, else the oldest one
    function automatic l2_addr_pkg::way_t pick_victim(input l2_addr_pkg::index_t idx);
        l2_addr_pkg::way_t v;
        v = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (ref_age[idx][w] == 2'd3)
                v = l2_addr_pkg::way_t'(w);
        end
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (!ref_valid[idx][w])
                v = l2_addr_pkg::way_t'(w);
        end
        return v;
    endfunction

    task automatic touch_model(input l2_addr_pkg::index_t idx, input l2_addr_pkg::way_t t);
        l2_ctrl_pkg::lru_age_t a;
        a = ref_age[idx][t];
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (ref_age[idx][w] < a)
                ref_age[idx][w] = ref_age[idx][w] + 2'd1;
        end
        ref_age[idx][t] = '0;
    endtask

    task automatic access(input string test, input logic wr, input l2_addr_pkg::tag_t tag,
                          input l2_addr_pkg::index_t idx);
        int                hw;
        int                n;
        int                refills;
        l2_addr_pkg::way_t exp_way;
        l2_addr_pkg::tag_t wb_tag;
        logic              exp_wb;
        logic              seen_miss;
        logic              seen_wb;
        logic              seen_rd;
        hw = -1;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag)
                hw = w;
        end
        exp_way = (hw >= 0) ? l2_addr_pkg::way_t'(hw) : pick_victim(idx);
        exp_wb = (hw < 0) && ref_valid[idx][exp_way] && ref_dirty[idx][exp_way];
        wb_tag = ref_tag[idx][exp_way];
        n = 0;
        refills = 0;
        seen_miss = 1'b0;
        seen_wb = 1'b0;
        seen_rd = 1'b0;
        @(posedge clk);
        read_l1_l2 <= !wr;
        write_l1_l2 <= wr;
        tag_l1_l2 <= tag;
        index_l1_l2 <= idx;
        do
        begin
            @(posedge clk);
            n++;
            if (l2_miss)
                seen_miss = 1'b1;
            if (refill)
                refills++;
            if (write_l2_mem && !seen_wb)
            begin
                seen_wb = 1'b1;
                expect_eq({test, " write-back tag"}, wb_tag, write_tag_l2_mem);
            end
            if (read_l2_mem && !seen_rd)
            begin
                seen_rd = 1'b1;
                expect_eq({test, " miss before refill"}, 1, seen_miss);
                expect_eq({test, " write-back before refill"}, exp_wb, seen_wb);
                expect_eq({test, " refill tag"}, tag, tag_l2_mem);
                expect_eq({test, " refill index"}, idx, index_l2_mem);
            end
        end
        while (!ready_l2_l1);
        read_l1_l2 <= 1'b0;
        write_l1_l2 <= 1'b0;
        expect_eq({test, " way"}, exp_way, way);
        expect_eq({test, " update"}, wr, update);
        expect_eq({test, " miss"}, hw < 0, seen_miss);
        expect_eq({test, " write-back"}, exp_wb, seen_wb);
        expect_eq({test, " memory read"}, hw < 0, seen_rd);
        expect_eq({test, " refill count"}, hw < 0, refills);
        // ready was registered at edge n-1, request sampled at edge 1
        if (hw >= 0)
            expect_eq({test, " hit latency"}, 2, n - 2);
        if (hw < 0)
        begin
            ref_tag[idx][exp_way] = tag;
            ref_valid[idx][exp_way] = 1'b1;
            ref_dirty[idx][exp_way] = 1'b0;
        end
        touch_model(idx, exp_way);
        if (wr)
            ref_dirty[idx][exp_way] = 1'b1;
    endtask

    task automatic flush_all();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        clear_model(1'b0);
    endtask

    initial
    begin
        forever
            #10 clk = ~clk;
    end

    // memory answers after 1 to 4 cycles
    always @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            ready_mem_l2 <= 1'b0;
            mem_armed <= 1'b0;
        end
        else if (ready_mem_l2)
        begin
            ready_mem_l2 <= 1'b0;
            mem_armed <= 1'b0;
        end
        else if (mem_armed)
        begin
            if (mem_wait <= 1)
                ready_mem_l2 <= 1'b1;
            mem_wait <= mem_wait - 1;
        end
        else if (read_l2_mem || write_l2_mem)
        begin
            mem_rng = xorshift32(mem_rng);
            mem_wait <= 1 + int'(mem_rng % 4);
            mem_armed <= 1'b1;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            abort_run("timeout: the run went past its cycle limit");
        else if (l2_controller_i.checker_i.violation)
            abort_run("a protocol assertion in the bound checker failed");
    end

    initial
    begin
        clear_model(1'b1);
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        expect_eq("reset outputs", 6'b0,
                  {ready_l2_l1, refill, update, read_l2_mem, write_l2_mem, l2_miss});
        access("cold read", 1'b0, 21'h0a5a5, 5'd3);
        access("repeat read", 1'b0, 21'h0a5a5, 5'd3);
        access("write hit", 1'b1, 21'h0a5a5, 5'd3);
        // fill set 9, then three evictions: dirty, clean, dirty
        access("fill way 0", 1'b1, 21'h10001, 5'd9);
        access("fill way 1", 1'b0, 21'h10002, 5'd9);
        access("fill way 2", 1'b1, 21'h10003, 5'd9);
        access("fill way 3", 1'b0, 21'h10004, 5'd9);
        access("evict dirty on read", 1'b0, 21'h10005, 5'd9);
        access("evict clean", 1'b1, 21'h10006, 5'd9);
        access("evict dirty again", 1'b0, 21'h10007, 5'd9);
        flush_all();
        access("read after flush", 1'b0, 21'h0a5a5, 5'd3);
        @(posedge clk);
        if (l2_controller_i.checker_i.violation)
            abort_run("a protocol assertion in the bound checker failed");
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+.
l2_addr_pkg.sv
l2_ctrl_pkg.sv
l2_tag_store.sv
l2_lru_tracker.sv
l2_sequencer.sv
l2_controller.sv
l2_controller_checker.sv
tb_l2_controller.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l2_controller \
    -f files.f \
    -o tb_l2_controller
./obj_dir/tb_l2_controller +verilator+error+limit+100
